// ==== filelist.f ====
i2s_proto_pkg.sv
rx_buf_pkg.sv
i2s_sync.sv
i2s_deserializer.sv
sample_fifo.sv
i2s_rx_top.sv
tb_i2s_rx.sv

// ==== i2s_deserializer.sv ====
`timescale 1ns/1ps

module i2s_deserializer (
    input  logic                               clk,      // system clock
    input  logic                               rst,      // async reset, active low
    input  logic                               en,       // reception enable level
    input  logic                               sck_rise, // sample strobe from sync
    input  logic                               ws_s,     // synced word select
    input  logic                               sd_s,     // synced serial data
    output logic [i2s_proto_pkg::word_bits-1:0] lft,     // left word of frame
    output logic [i2s_proto_pkg::word_bits-1:0] rgt,     // right word of frame
    output logic                               xfc       // transfer complete pulse
);

    import i2s_proto_pkg::*;

    logic [word_bits-1:0]    shift_reg; // bits of the word in progress
    logic [word_bits-1:0]    word_next; // shift_reg plus the bit sampled now
    logic [word_bits-1:0]    left_hold; // completed left word, waits for right
    logic [bit_cnt_bits-1:0] bit_cnt;   // bits taken in this word, saturates
    logic                    ws_q;      // ws at the previous sck_rise
    logic                    aligned;   // saw a ws edge into left since en rose
    logic                    left_seen; // left word latched for this frame
    logic                    word_end;  // ws flipped, current bit is the LSB
    logic                    left_done; // left word complete and usable
    logic                    right_done; // right word completes a frame

    // current bit lands at its MSB-first slot
    // short words leave the low bits at zero, long words drop the extra bits
    always_comb
    begin
        word_next = shift_reg;
        if (bit_cnt < bit_cnt_bits'(word_bits))
        begin
            word_next[word_bits - 1 - int'(bit_cnt)] = sd_s;
        end
    end

    // ws changes one bit early, so the first sample with new ws still
    // belongs to the old channel's word
    assign word_end   = sck_rise & en & (ws_s != ws_q);
    assign left_done  = word_end & (ws_q == chan_left) & aligned;
    assign right_done = word_end & (ws_q == chan_right) & aligned & left_seen;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ws_q      <= chan_left;
            aligned   <= 1'b0;
            left_seen <= 1'b0;
            bit_cnt   <= '0;
            shift_reg <= '0;
            xfc       <= 1'b0;
        end
        else
        begin
            xfc <= right_done; // one clk after the right LSB sample

            // ws is tracked even while disabled, otherwise a stale value
            // would fake an edge right after en rises
            if (sck_rise)
            begin
                ws_q <= ws_s;
            end

            if (!en)
            begin
                aligned   <= 1'b0; // realign after re-enable
                left_seen <= 1'b0;
                bit_cnt   <= '0;   // partial word thrown away
                shift_reg <= '0;
            end
            else if (sck_rise)
            begin
                if (word_end)
                begin
                    bit_cnt   <= '0; // next sample is the new MSB
                    shift_reg <= '0;
                    if (ws_s == chan_left)
                    begin
                        aligned <= 1'b1; // edge into left, frames start here
                    end
                    if (ws_q == chan_left)
                    begin
                        left_seen <= aligned; // left word counts only once aligned
                    end
                    else
                    begin
                        left_seen <= 1'b0; // frame done or dropped
                    end
                end
                else
                begin
                    shift_reg <= word_next;
                    if (bit_cnt != bit_cnt_bits'(word_bits))
                    begin
                        bit_cnt <= bit_cnt + 1'b1; // stop at word_bits
                    end
                end
            end
        end
    end

    // word payload, only read together with xfc
    always_ff @(posedge clk)
    begin
        if (left_done)
        begin
            left_hold <= word_next; // park left until right arrives
        end
        if (right_done)
        begin
            lft <= left_hold;
            rgt <= word_next;
        end
    end

    // frames only leave while reception is enabled
    a_xfc_enabled: assert property (
        @(posedge clk) disable iff (!rst)
        xfc |-> en
    ) else $error("xfc without enable");

endmodule

// ==== i2s_proto_pkg.sv ====
package i2s_proto_pkg;

    // audio word format, fixed standard I2S
    localparam int word_bits = 16; // bits per audio word

    // bit counter has to reach word_bits itself to saturate there
    localparam int bit_cnt_bits = $clog2(word_bits + 1); // 5 bits for 16

    // ws level per channel
    localparam logic chan_left  = 1'b0; // ws low selects left
    localparam logic chan_right = 1'b1; // ws high selects right

    // flops per pin in the clk domain synchronizer
    localparam int sync_stages = 2; // pin edge to sck_rise is sync_stages + 1

    // sck_rise is registered once after the chain, so the pin to strobe delay
    // grows by one cycle on top of the synchronizer depth
    localparam int sync_latency = sync_stages + 1; // clk cycles

    // the serial clock must hold each level long enough for the chain
    // to see it as a stable level
    localparam int sck_min_half = sync_latency; // clk cycles high and low

endpackage

// ==== i2s_rx_top.sv ====
`timescale 1ns/1ps

module i2s_rx_top (
    input  logic                               clk,      // system clock
    input  logic                               rst,      // async reset, active low
    input  logic                               i2s_sck,  // serial clock pin
    input  logic                               i2s_ws,   // word select pin
    input  logic                               i2s_sd,   // serial data pin
    input  logic                               en,       // reception enable
    input  logic                               pop,      // remove head frame
    output logic [i2s_proto_pkg::word_bits-1:0] lft,     // head frame left word
    output logic [i2s_proto_pkg::word_bits-1:0] rgt,     // head frame right word
    output logic                               valid,    // frame available
    output logic                               overflow  // frame was dropped
);

    import i2s_proto_pkg::*;

    logic                 sck_rise; // sck edge strobe in clk domain
    logic                 ws_s;     // synced ws
    logic                 sd_s;     // synced sd
    logic [word_bits-1:0] des_lft;  // assembled left word
    logic [word_bits-1:0] des_rgt;  // assembled right word
    logic                 des_xfc;  // frame complete strobe

    // pins into the clk domain
    i2s_sync i_i2s_sync (
        .clk      (clk),
        .rst      (rst),
        .sck      (i2s_sck),
        .ws       (i2s_ws),
        .sd       (i2s_sd),
        .sck_rise (sck_rise),
        .ws_s     (ws_s),
        .sd_s     (sd_s)
    );

    // serial bits to stereo frames
    i2s_deserializer i_i2s_deserializer (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .sck_rise (sck_rise),
        .ws_s     (ws_s),
        .sd_s     (sd_s),
        .lft      (des_lft),
        .rgt      (des_rgt),
        .xfc      (des_xfc)
    );

    // frames wait here for the consumer
    sample_fifo i_sample_fifo (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .push     (des_xfc),
        .push_lft (des_lft),
        .push_rgt (des_rgt),
        .pop      (pop),
        .lft      (lft),
        .rgt      (rgt),
        .valid    (valid),
        .overflow (overflow)
    );

endmodule

// ==== i2s_sync.sv ====
`timescale 1ns/1ps

module i2s_sync (
    input  logic clk,      // system clock
    input  logic rst,      // async reset, active low
    input  logic sck,      // serial clock pin, async to clk
    input  logic ws,       // word select pin
    input  logic sd,       // serial data pin
    output logic sck_rise, // one clk per rising sck
    output logic ws_s,     // ws sample, valid with sck_rise
    output logic sd_s      // sd sample, valid with sck_rise
);

    import i2s_proto_pkg::*;

    logic [sync_stages-1:0]  sck_sync; // sck synchronizer chain
    logic [sync_stages-1:0]  ws_sync;  // ws synchronizer chain
    logic [sync_stages-1:0]  sd_sync;  // sd synchronizer chain
    logic                    sck_d1;   // last synced sck, for edge detect
    logic [sck_min_half-2:0] sck_hist; // older synced sck levels, behind sck_d1

    // all three pins ride identical chains so ws and sd stay lined up
    // with the sck edge that samples them
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            sck_sync <= '0;
            ws_sync  <= '0;
            sd_sync  <= '0;
            sck_d1   <= 1'b0;
            sck_hist <= '0;
            sck_rise <= 1'b0;
            ws_s     <= 1'b0;
            sd_s     <= 1'b0;
        end
        else
        begin
            sck_sync <= {sck_sync[sync_stages-2:0], sck}; // shift in new pin level
            ws_sync  <= {ws_sync[sync_stages-2:0], ws};
            sd_sync  <= {sd_sync[sync_stages-2:0], sd};
            sck_d1   <= sck_sync[sync_stages-1]; // one cycle behind chain output
            sck_hist <= {sck_hist[sck_min_half-3:0], sck_d1}; // level history
            sck_rise <= sck_sync[sync_stages-1] & ~sck_d1; // registered rising edge
            ws_s     <= ws_sync[sync_stages-1]; // same stage count as sck_rise
            sd_s     <= sd_sync[sync_stages-1];
        end
    end

    // each sck level must last sck_min_half clk, so rises never come back to back
    a_sck_hold: assert property (
        @(posedge clk) disable iff (!rst)
        (sck_sync[sync_stages-1] != sck_d1) |-> (sck_hist == {(sck_min_half-1){sck_d1}})
    ) else $error("sck level held shorter than sck_min_half clk cycles");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the I2S receive testbench with Verilator, run it, judge from the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_i2s_rx -f filelist.f \
    > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/Vtb_i2s_rx > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && echo "simulation ok" && exit 0 \
    || { echo "simulation not ok"; exit 1; }

// ==== rx_buf_pkg.sv ====
package rx_buf_pkg;

    // stereo frame buffer between deserializer and consumer

    localparam int fifo_depth = 8; // stereo frames held

    // read and write pointers index one frame slot each
    localparam int ptr_bits = $clog2(fifo_depth); // 3 for 8 frames

    // the frame count needs one bit more than a pointer
    // since it has to show a full buffer
    localparam int cnt_bits = ptr_bits + 1; // 0..fifo_depth

    // last slot index, pointers wrap here
    localparam int last_slot = fifo_depth - 1;

    // a push at full is dropped and flags overflow
    // overflow is cleared only by en going low
    // the buffer keeps its frames while en is low

endpackage

// ==== sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo (
    input  logic                               clk,      // system clock
    input  logic                               rst,      // async reset, active low
    input  logic                               en,       // low clears overflow
    input  logic                               push,     // frame strobe from deserializer
    input  logic [i2s_proto_pkg::word_bits-1:0] push_lft, // left word to store
    input  logic [i2s_proto_pkg::word_bits-1:0] push_rgt, // right word to store
    input  logic                               pop,      // consumer removes head
    output logic [i2s_proto_pkg::word_bits-1:0] lft,     // head frame left
    output logic [i2s_proto_pkg::word_bits-1:0] rgt,     // head frame right
    output logic                               valid,    // buffer not empty
    output logic                               overflow  // sticky, frame was dropped
);

    import i2s_proto_pkg::*;
    import rx_buf_pkg::*;

    logic [word_bits-1:0] mem_lft [fifo_depth]; // left word per slot
    logic [word_bits-1:0] mem_rgt [fifo_depth]; // right word per slot
    logic [ptr_bits-1:0]  wr_ptr;  // next free slot
    logic [ptr_bits-1:0]  rd_ptr;  // head slot
    logic [cnt_bits-1:0]  count;   // frames held
    logic                 full;
    logic                 do_push; // push accepted
    logic                 do_pop;  // pop accepted

    assign full    = (count == cnt_bits'(fifo_depth));
    assign valid   = (count != '0);
    assign do_push = push & ~full; // full buffer drops the frame
    assign do_pop  = pop & valid;  // pop on empty does nothing

    // head shown only while something is stored, zero otherwise
    assign lft = valid ? mem_lft[rd_ptr] : '0;
    assign rgt = valid ? mem_rgt[rd_ptr] : '0;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == ptr_bits'(last_slot)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == ptr_bits'(last_slot)) ? '0 : rd_ptr + 1'b1;
            end

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase

            if (!en)
            begin
                overflow <= 1'b0; // cleared by disabling reception
            end
            else if (push && full)
            begin
                overflow <= 1'b1; // frame lost, stays set
            end
        end
    end

    // frame storage
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem_lft[wr_ptr] <= push_lft;
            mem_rgt[wr_ptr] <= push_rgt;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst)
        count <= cnt_bits'(fifo_depth)
    ) else $error("frame count above fifo_depth");

    // empty pop with no push must not move either pointer
    a_empty_pop: assert property (
        @(posedge clk) disable iff (!rst)
        (pop && !valid && !push) |=> ($stable(rd_ptr) && $stable(wr_ptr))
    ) else $error("pointer moved on empty pop");

endmodule

// ==== tb_i2s_rx.sv ====
`timescale 1ns/1ps

module tb_i2s_rx;

    import i2s_proto_pkg::*;
    import rx_buf_pkg::*;

    localparam int n_rows   = 27;               // stimulus table rows
    localparam int sck_half = sync_latency + 2; // clk per sck level, spans pin to valid
    localparam int wait_max = 200;              // clk cycles before a wait gives up

    logic                 clk;
    logic                 rst;
    logic                 i2s_sck;
    logic                 i2s_ws;
    logic                 i2s_sd;
    logic                 en;
    logic                 pop;
    logic [word_bits-1:0] lft;
    logic [word_bits-1:0] rgt;
    logic                 valid;
    logic                 overflow;

    logic [word_bits-1:0] tab_lft  [n_rows]; // left word sent
    logic [word_bits-1:0] tab_rgt  [n_rows]; // right word sent
    logic                 tab_en   [n_rows]; // en level for the whole frame
    int                   tab_pops [n_rows]; // pops issued after the frame

    logic [word_bits-1:0] exp_lft [$]; // frames the FIFO should hold
    logic [word_bits-1:0] exp_rgt [$];
    logic                 exp_ovf;     // predicted overflow level
    logic                 exp_aligned; // predicted alignment of the deserializer
    logic [31:0]          rng;
    int                   n_checks;
    int                   n_errors;

    i2s_rx_top i_i2s_rx_top (
        .clk      (clk),
        .rst      (rst),
        .i2s_sck  (i2s_sck),
        .i2s_ws   (i2s_ws),
        .i2s_sd   (i2s_sd),
        .en       (en),
        .pop      (pop),
        .lft      (lft),
        .rgt      (rgt),
        .valid    (valid),
        .overflow (overflow)
    );

    always #2 clk = ~clk; // 4 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void fill_table();
        for (int i = 0; i < n_rows; i++)
        begin
            rng         = xorshift(rng);
            tab_lft[i]  = rng[15:0];
            tab_rgt[i]  = rng[31:16];
            tab_en[i]   = 1'b1;
            tab_pops[i] = (i >= 5 && i <= 17) ? 0 : 1; // rows 5..14 overrun, 15..16 stay
        end
        tab_lft[0] = 16'h1111; // sent while disabled
        tab_rgt[0] = 16'h2222;
        tab_en[0]  = 1'b0;
        tab_lft[1] = 16'hAAAA; // partial frame after en rises, dropped
        tab_rgt[1] = 16'hFFFF;
        tab_lft[2] = 16'hAAAA;
        tab_rgt[2] = 16'hFFFF;
        tab_lft[3] = 16'h1478;
        tab_rgt[3] = 16'hA3B9;
        tab_lft[4] = 16'h0001;
        tab_rgt[4] = 16'hFFFF;
        tab_pops[14] = fifo_depth; // drain after overflow
        tab_en[17]   = 1'b0;       // disabled, two frames still stored
        tab_en[18]   = 1'b0;
        tab_pops[18] = 2;
        tab_pops[19] = 0;          // realign frame
        tab_pops[25] = 2;          // second pop hits an empty FIFO
    endfunction

    task automatic after_edge();
        @(posedge clk);
        #1; // inputs move just after the edge
    endtask

    task automatic check_word(input string name, input logic [word_bits-1:0] exp_v,
                              input logic [word_bits-1:0] act);
        n_checks++;
        if (act !== exp_v)
        begin
            $display("** Error: %s expected %h got %h", name, exp_v, act);
            n_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act);
        n_checks++;
        if (act !== exp_v)
        begin
            $display("** Error: %s expected %h got %h", name, exp_v, act);
            n_errors++;
        end
    endtask

    task automatic wait_valid();
        int cycles;
        cycles = 0;
        while (valid !== 1'b1 && cycles < wait_max)
        begin
            after_edge();
            cycles++;
        end
        if (valid !== 1'b1)
        begin
            $display("timeout: valid did not rise within %0d clk cycles", wait_max);
            n_errors++;
        end
    endtask

    // one sck period, tx side changes on the falling edge
    task automatic send_bit(input logic ws_val, input logic sd_val);
        i2s_sck = 1'b0;
        i2s_ws  = ws_val;
        i2s_sd  = sd_val;
        repeat (sck_half) after_edge();
        i2s_sck = 1'b1; // rx samples here
        repeat (sck_half) after_edge();
    endtask

    task automatic send_frame(input logic [word_bits-1:0] l, input logic [word_bits-1:0] r);
        for (int i = word_bits - 1; i >= 0; i--)
        begin
            send_bit((i == 0) ? chan_right : chan_left, l[i]); // ws flips one bit early
        end
        for (int i = word_bits - 1; i >= 0; i--)
        begin
            send_bit((i == 0) ? chan_left : chan_right, r[i]);
        end
    endtask

    // prediction from the I2S framing and FIFO rules
    task automatic model_frame(input int row);
        if (!tab_en[row])
        begin
            exp_aligned = 1'b0;
            exp_ovf     = 1'b0;
        end
        else if (!exp_aligned)
        begin
            exp_aligned = 1'b1; // frame ends on a ws edge into left
        end
        else if (exp_lft.size() < fifo_depth)
        begin
            exp_lft.push_back(tab_lft[row]);
            exp_rgt.push_back(tab_rgt[row]);
        end
        else
        begin
            exp_ovf = 1'b1; // frame dropped at full
        end
    endtask

    task automatic pop_once();
        if (exp_lft.size() != 0)
        begin
            wait_valid();
            check_word("lft", exp_lft[0], lft);
            check_word("rgt", exp_rgt[0], rgt);
            exp_lft.delete(0);
            exp_rgt.delete(0);
        end
        else
        begin
            check_flag("valid", 1'b0, valid); // pop on empty
        end
        pop = 1'b1;
        after_edge();
        pop = 1'b0;
        after_edge(); // head settles one clk after the pop
    endtask

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b0;
        i2s_sck     = 1'b1; // sck idles high
        i2s_ws      = chan_left;
        i2s_sd      = 1'b0;
        en          = 1'b0;
        pop         = 1'b0;
        exp_ovf     = 1'b0;
        exp_aligned = 1'b0;
        n_checks    = 0;
        n_errors    = 0;
        rng         = 32'd44617;
        fill_table();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;
        after_edge();
        after_edge();
        check_flag("valid", 1'b0, valid);
        check_flag("overflow", 1'b0, overflow);
        check_word("lft", '0, lft);
        check_word("rgt", '0, rgt);

        for (int row = 0; row < n_rows; row++)
        begin
            en = tab_en[row];
            after_edge();
            send_frame(tab_lft[row], tab_rgt[row]); // ends when valid has to show it
            model_frame(row);
            check_flag("valid", exp_lft.size() != 0, valid); // pin to valid latency
            check_flag("overflow", exp_ovf, overflow);
            for (int k = 0; k < tab_pops[row]; k++)
            begin
                pop_once();
            end
            check_flag("valid", exp_lft.size() != 0, valid); // falls after last pop
        end

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
